// ==== hdl/motor_pwm_pkg.sv ====
`default_nettype none

package motor_pwm_pkg;

    // ------------------------------------------------------------------
    // Carrier timing
    // ------------------------------------------------------------------

    // Clocks in one carrier ramp, up or down.
    localparam int carrier_period = 200;

    // Largest on-time a phase may get within one ramp.
    localparam int max_on_cycles = 196;

    localparam int counter_width = $clog2(carrier_period);

    // Last count of a ramp and the clamp value, sized for the counter.
    localparam logic [counter_width-1:0] count_top   = counter_width'(carrier_period - 1);
    localparam logic [counter_width-1:0] count_clamp = counter_width'(max_on_cycles);

    // ------------------------------------------------------------------
    // Data and bus widths
    // ------------------------------------------------------------------

    localparam int duty_width    = 12;
    localparam int wb_data_width = 32;
    localparam int wb_addr_width = 3;

    // Bit positions in the control and status words.
    localparam int ctrl_enable_bit   = 0;
    localparam int ctrl_clear_bit    = 1;
    localparam int status_fault_bit  = 0;
    localparam int status_enable_bit = 1;

    // Word addresses of the register block.
    typedef enum logic [wb_addr_width-1:0] {
        reg_ctrl   = 3'd0,
        reg_duty_u = 3'd1,
        reg_duty_v = 3'd2,
        reg_duty_w = 3'd3,
        reg_commit = 3'd4,
        reg_status = 3'd5
    } reg_addr_e;

endpackage

`default_nettype wire

// ==== hdl/pwm_wb_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_wb_regs (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire                                     wb_cyc,
    input  wire                                     wb_stb,
    input  wire                                     wb_we,
    input  wire  [motor_pwm_pkg::wb_addr_width-1:0] wb_adr,
    input  wire  [motor_pwm_pkg::wb_data_width-1:0] wb_dat_w,
    input  wire                                     fault,
    output logic [motor_pwm_pkg::wb_data_width-1:0] wb_dat_r,
    output logic                                    wb_ack,
    output logic                                    enable,
    output logic                                    fault_clear,
    output logic                                    pwm_valid,
    output logic [3*motor_pwm_pkg::duty_width-1:0]  pwm_data
);

    logic                                    wb_access;
    logic                                    wr_en;
    motor_pwm_pkg::reg_addr_e                addr;
    logic [motor_pwm_pkg::duty_width-1:0]    duty_u;
    logic [motor_pwm_pkg::duty_width-1:0]    duty_v;
    logic [motor_pwm_pkg::duty_width-1:0]    duty_w;
    logic [motor_pwm_pkg::wb_data_width-1:0] read_data;

    // A new access is taken only while no acknowledge is out, so each
    // strobe gets exactly one ack.
    assign wb_access = wb_cyc & wb_stb & ~wb_ack;
    assign wr_en     = wb_access & wb_we;
    assign addr      = motor_pwm_pkg::reg_addr_e'(wb_adr);

    assign pwm_data = {duty_u, duty_v, duty_w};

    // ------------------------------------------------------------------
    // Control state and pulses
    // ------------------------------------------------------------------

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wb_ack      <= 1'b0;
            enable      <= 1'b0;
            fault_clear <= 1'b0;
            pwm_valid   <= 1'b0;
        end else begin
            wb_ack      <= wb_access;
            fault_clear <= 1'b0;
            pwm_valid   <= 1'b0;
            if (wr_en) begin
                case (addr)
                    motor_pwm_pkg::reg_ctrl: begin
                        enable      <= wb_dat_w[motor_pwm_pkg::ctrl_enable_bit];
                        fault_clear <= wb_dat_w[motor_pwm_pkg::ctrl_clear_bit];
                    end
                    motor_pwm_pkg::reg_commit: begin
                        pwm_valid <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Duty values and read data.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            case (addr)
                motor_pwm_pkg::reg_duty_u: duty_u <= wb_dat_w[motor_pwm_pkg::duty_width-1:0];
                motor_pwm_pkg::reg_duty_v: duty_v <= wb_dat_w[motor_pwm_pkg::duty_width-1:0];
                motor_pwm_pkg::reg_duty_w: duty_w <= wb_dat_w[motor_pwm_pkg::duty_width-1:0];
                default: begin
                end
            endcase
        end
        if (wb_access) begin
            wb_dat_r <= read_data;
        end
    end

    // ------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------

    always_comb begin
        read_data = '0;
        case (addr)
            motor_pwm_pkg::reg_ctrl: begin
                read_data[motor_pwm_pkg::ctrl_enable_bit] = enable;
            end
            motor_pwm_pkg::reg_duty_u: read_data[motor_pwm_pkg::duty_width-1:0] = duty_u;
            motor_pwm_pkg::reg_duty_v: read_data[motor_pwm_pkg::duty_width-1:0] = duty_v;
            motor_pwm_pkg::reg_duty_w: read_data[motor_pwm_pkg::duty_width-1:0] = duty_w;
            motor_pwm_pkg::reg_status: begin
                read_data[motor_pwm_pkg::status_fault_bit]  = fault;
                read_data[motor_pwm_pkg::status_enable_bit] = enable;
            end
            default: begin
                read_data = '0;
            end
        endcase
    end

    // The ack always answers a strobe seen one clock earlier.
    ack_follows_strobe: assert property (
        @(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb)
    );

    // Each commit launches one update only.
    valid_single_pulse: assert property (
        @(posedge clk) disable iff (reset)
        pwm_valid |=> !pwm_valid
    );

endmodule

`default_nettype wire

// ==== hdl/pwm_carrier_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module pwm_carrier_timing (
    input  wire  clk,
    input  wire  reset,
    input  wire  enable,
    input  wire  fault_in,
    input  wire  fault_clear,
    output logic trigger,
    output logic fault
);

    logic [motor_pwm_pkg::counter_width-1:0] count;
    logic                                    fault_meta;
    logic                                    fault_sync;

    // ------------------------------------------------------------------
    // Carrier trigger
    // ------------------------------------------------------------------

    // The counter sits at the top value while disabled, so the first
    // trigger comes one full period after enable rises.
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            count   <= motor_pwm_pkg::count_top;
            trigger <= 1'b0;
        end else begin
            trigger <= 1'b0;
            if (!enable) begin
                count <= motor_pwm_pkg::count_top;
            end else if (count == '0) begin
                count   <= motor_pwm_pkg::count_top;
                trigger <= 1'b1;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Fault synchronizer and latch
    // ------------------------------------------------------------------

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            fault_meta <= 1'b0;
            fault_sync <= 1'b0;
            fault      <= 1'b0;
        end else begin
            fault_meta <= fault_in;
            fault_sync <= fault_meta;
            if (fault_sync) begin
                fault <= 1'b1;
            end else if (fault_clear) begin
                // A clear is ignored while the input is still active.
                fault <= 1'b0;
            end
        end
    end

    trigger_one_clock: assert property (
        @(posedge clk) disable iff (reset)
        trigger |=> !trigger
    );

endmodule

`default_nettype wire

// ==== hdl/ds_pwm_driver.sv ====
`timescale 1ns/1ns
`default_nettype none

module ds_pwm_driver (
    input  wire                                    clk,
    input  wire                                    reset,
    input  wire                                    trigger,
    input  wire                                    fault,
    input  wire                                    pwm_valid,
    input  wire [3*motor_pwm_pkg::duty_width-1:0]  pwm_data,
    output logic [2:0]                             driver_pwm,
    output logic [2:0]                             driver_reset_n
);

    logic [motor_pwm_pkg::duty_width-1:0]    duty_u;
    logic [motor_pwm_pkg::duty_width-1:0]    duty_v;
    logic [motor_pwm_pkg::duty_width-1:0]    duty_w;
    logic                                    dir;
    logic [motor_pwm_pkg::counter_width-1:0] counter;
    logic                                    drive;
    logic                                    update;
    logic [motor_pwm_pkg::counter_width-1:0] u_compare;
    logic [motor_pwm_pkg::counter_width-1:0] v_compare;
    logic [motor_pwm_pkg::counter_width-1:0] w_compare;
    logic [motor_pwm_pkg::counter_width-1:0] u_compare_next;
    logic [motor_pwm_pkg::counter_width-1:0] v_compare_next;
    logic [motor_pwm_pkg::counter_width-1:0] w_compare_next;
    logic [2:0]                              pwm_stage;
    logic                                    drive_stage;

    assign duty_u = pwm_data[2*motor_pwm_pkg::duty_width +: motor_pwm_pkg::duty_width];
    assign duty_v = pwm_data[1*motor_pwm_pkg::duty_width +: motor_pwm_pkg::duty_width];
    assign duty_w = pwm_data[0*motor_pwm_pkg::duty_width +: motor_pwm_pkg::duty_width];

    // Limits a duty to the largest allowed on-time.
    function automatic logic [motor_pwm_pkg::counter_width-1:0] clamp(
        input logic [motor_pwm_pkg::duty_width-1:0] duty
    );
        if (duty < motor_pwm_pkg::max_on_cycles) begin
            return duty[motor_pwm_pkg::counter_width-1:0];
        end
        return motor_pwm_pkg::count_clamp;
    endfunction

    // Pending compares, loaded on every commit.
    always_ff @(posedge clk) begin
        if (pwm_valid) begin
            u_compare_next <= clamp(duty_u);
            v_compare_next <= clamp(duty_v);
            w_compare_next <= clamp(duty_w);
        end
    end

    // ------------------------------------------------------------------
    // Triangle carrier and compare update
    // ------------------------------------------------------------------

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            dir       <= 1'b0;
            counter   <= '0;
            drive     <= 1'b0;
            update    <= 1'b0;
            u_compare <= '0;
            v_compare <= '0;
            w_compare <= '0;
        end else begin
            update <= (pwm_valid | (update & ~trigger)) & ~fault;
            if (trigger) begin
                dir <= ~dir;
            end
            if (fault) begin
                drive <= 1'b0;
            end else if (trigger) begin
                // dir still holds the old direction here.
                counter <= dir ? '0 : motor_pwm_pkg::count_top;
                if (update) begin
                    drive     <= 1'b1;
                    u_compare <= u_compare_next;
                    v_compare <= v_compare_next;
                    w_compare <= w_compare_next;
                end
            end else if (!dir) begin
                if (counter < motor_pwm_pkg::count_top) begin
                    counter <= counter + 1'b1;
                end
            end else if (counter != '0) begin
                counter <= counter - 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // Output pipeline
    // ------------------------------------------------------------------

    // Bit 0 carries w and bit 2 carries u.
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            pwm_stage      <= '0;
            drive_stage    <= 1'b0;
            driver_pwm     <= '0;
            driver_reset_n <= '0;
        end else begin
            pwm_stage[0]   <= drive & (counter < w_compare);
            pwm_stage[1]   <= drive & (counter < v_compare);
            pwm_stage[2]   <= drive & (counter < u_compare);
            drive_stage    <= drive;
            driver_pwm     <= pwm_stage;
            driver_reset_n <= {3{drive_stage}};
        end
    end

    gate_only_when_released: assert property (
        @(posedge clk) disable iff (reset)
        (|driver_pwm) |-> (&driver_reset_n)
    );

endmodule

`default_nettype wire

// ==== hdl/motor_pwm_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module motor_pwm_top (
    input  wire                                     clk,
    input  wire                                     reset,
    input  wire                                     wb_cyc,
    input  wire                                     wb_stb,
    input  wire                                     wb_we,
    input  wire  [motor_pwm_pkg::wb_addr_width-1:0] wb_adr,
    input  wire  [motor_pwm_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [motor_pwm_pkg::wb_data_width-1:0] wb_dat_r,
    output logic                                    wb_ack,
    input  wire                                     fault_in,
    output logic [2:0]                              driver_pwm,
    output logic [2:0]                              driver_reset_n
);

    logic                                   enable;
    logic                                   fault_clear;
    logic                                   pwm_valid;
    logic [3*motor_pwm_pkg::duty_width-1:0] pwm_data;
    logic                                   trigger;
    logic                                   fault;

    pwm_wb_regs u_pwm_wb_regs (
        .clk         (clk),
        .reset       (reset),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .fault       (fault),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .enable      (enable),
        .fault_clear (fault_clear),
        .pwm_valid   (pwm_valid),
        .pwm_data    (pwm_data)
    );

    pwm_carrier_timing u_pwm_carrier_timing (
        .clk         (clk),
        .reset       (reset),
        .enable      (enable),
        .fault_in    (fault_in),
        .fault_clear (fault_clear),
        .trigger     (trigger),
        .fault       (fault)
    );

    ds_pwm_driver u_ds_pwm_driver (
        .clk            (clk),
        .reset          (reset),
        .trigger        (trigger),
        .fault          (fault),
        .pwm_valid      (pwm_valid),
        .pwm_data       (pwm_data),
        .driver_pwm     (driver_pwm),
        .driver_reset_n (driver_reset_n)
    );

endmodule

`default_nettype wire

// ==== sim/tb_motor_pwm.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_motor_pwm;

    localparam int wb_timeout   = 16;
    localparam int idle_timeout = 4 * motor_pwm_pkg::carrier_period;
    localparam int window       = 2 * motor_pwm_pkg::carrier_period;

    logic                                    clk;
    logic                                    reset;
    logic                                    wb_cyc;
    logic                                    wb_stb;
    logic                                    wb_we;
    logic [motor_pwm_pkg::wb_addr_width-1:0] wb_adr;
    logic [motor_pwm_pkg::wb_data_width-1:0] wb_dat_w;
    logic [motor_pwm_pkg::wb_data_width-1:0] wb_dat_r;
    logic                                    wb_ack;
    logic                                    fault_in;
    logic [2:0]                              driver_pwm;
    logic [2:0]                              driver_reset_n;

    int check_errors;
    int timeout_errors;
    int other_errors;

    motor_pwm_top u_motor_pwm_top (
        .clk            (clk),
        .reset          (reset),
        .wb_cyc         (wb_cyc),
        .wb_stb         (wb_stb),
        .wb_we          (wb_we),
        .wb_adr         (wb_adr),
        .wb_dat_w       (wb_dat_w),
        .wb_dat_r       (wb_dat_r),
        .wb_ack         (wb_ack),
        .fault_in       (fault_in),
        .driver_pwm     (driver_pwm),
        .driver_reset_n (driver_reset_n)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------
    // Wishbone master
    // ------------------------------------------------------------------

    // One classic transfer. It starts and ends on a falling edge.
    task automatic wb_transfer(input logic we,
                               input logic [motor_pwm_pkg::wb_addr_width-1:0] adr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        cycles   = 0;
        rdata    = '0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        @(negedge clk);
        while (!wb_ack && cycles < wb_timeout) begin
            cycles++;
            @(negedge clk);
        end
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            timeout_errors++;
            $display("Timeout at %0t ns: no Wishbone acknowledge for address %0d",
                     $time, adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
        // The ack must be gone one clock later.
        check_value("wb_ack", 32'd0, {31'd0, wb_ack});
    endtask

    task automatic read_and_compare(input logic [motor_pwm_pkg::wb_addr_width-1:0] adr,
                                    input logic [31:0] expected);
        logic [31:0] rdata;
        wb_transfer(1'b0, adr, 32'd0, rdata);
        check_value("wb_dat_r", expected, rdata);
    endtask

    // ------------------------------------------------------------------
    // Output observation
    // ------------------------------------------------------------------

    // Phase 0 is u on bit 2, phase 2 is w on bit 0.
    task automatic measure_phase(input int phase, input logic [31:0] expected);
        int high_count;
        int bit_idx;
        string name;
        high_count = 0;
        bit_idx    = 2 - phase;
        repeat (window) begin
            @(negedge clk);
            if (driver_pwm[bit_idx]) begin
                high_count++;
            end
        end
        name = $sformatf("driver_pwm[%0d] high count", bit_idx);
        check_value(name, expected, high_count);
    endtask

    task automatic wait_reset_n(input logic [2:0] target);
        int cycles;
        cycles = 0;
        while (driver_reset_n !== target && cycles < idle_timeout) begin
            cycles++;
            @(negedge clk);
        end
        if (driver_reset_n !== target) begin
            timeout_errors++;
            $display("Timeout at %0t ns: driver_reset_n did not reach %b in %0d clocks",
                     $time, target, idle_timeout);
        end else if (target == 3'b000) begin
            check_value("driver_pwm", 32'd0, {29'd0, driver_pwm});
        end
    endtask

    task automatic run_operation(input logic [7:0] op, input logic [31:0] arg_a,
                                 input logic [31:0] arg_b, input int line_no);
        logic [31:0] rdata;
        case (op)
            "W": wb_transfer(1'b1, arg_a[motor_pwm_pkg::wb_addr_width-1:0], arg_b, rdata);
            "R": read_and_compare(arg_a[motor_pwm_pkg::wb_addr_width-1:0], arg_b);
            "M": measure_phase(arg_a, arg_b);
            "F": begin
                fault_in = arg_b[0];
                @(negedge clk);
            end
            "I": wait_reset_n(arg_b[2:0]);
            "S": repeat (arg_b) @(negedge clk);
            default: begin
                other_errors++;
                $display("Unknown operation '%c' on pattern line %0d", op, line_no);
            end
        endcase
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int          fd;
        int          status;
        int          fields;
        int          line_no;
        int          op_count;
        string       line;
        logic [7:0]  op;
        logic [31:0] arg_a;
        logic [31:0] arg_b;

        check_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        line_no        = 0;
        op_count       = 0;
        clk            = 1'b0;
        reset          = 1'b1;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        fault_in       = 1'b0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        // Quiet outputs and a clear status before the first command.
        check_value("driver_pwm", 32'd0, {29'd0, driver_pwm});
        check_value("driver_reset_n", 32'd0, {29'd0, driver_reset_n});
        read_and_compare(motor_pwm_pkg::reg_status, 32'd0);

        fd = $fopen("sim/motor_pwm_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("The pattern file sim/motor_pwm_patterns.txt could not be opened");
        end else begin
            while (!$feof(fd)) begin
                line   = "";
                status = $fgets(line, fd);
                line_no++;
                if (status != 0 && line.len() > 4 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%c %h %h", op, arg_a, arg_b);
                    if (fields != 3) begin
                        other_errors++;
                        $display("Pattern line %0d could not be parsed", line_no);
                    end else begin
                        op_count++;
                        run_operation(op, arg_a, arg_b, line_no);
                    end
                end
            end
            $fclose(fd);
            if (op_count == 0) begin
                other_errors++;
                $display("The pattern file holds no operations");
            end
        end

        $display("Error counts: %0d check errors, %0d timeouts, %0d other errors",
                 check_errors, timeout_errors, other_errors);
        if (check_errors + timeout_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/motor_pwm_patterns.txt ====
# Columns: op, address or phase, data or expected value, all hex.
# W write, R read and compare, M phase (0 u, 1 v, 2 w) high count over 400 clocks,
# F fault_in level, I wait for driver_reset_n value, S idle clocks.
W 1 00000064
W 2 000000fa
W 3 00000000
W 0 00000001
R 1 00000064
R 2 000000fa
R 3 00000000
R 0 00000001
R 5 00000002
W 4 00000000
I 0 00000007
M 0 000000c8
M 1 00000188
M 2 00000000
W 1 00000032
W 2 00000096
W 3 000000c4
R 1 00000032
M 0 000000c8
M 1 00000188
M 2 00000000
W 4 00000000
S 0 000000e0
M 0 00000064
M 1 0000012c
M 2 00000188
F 0 00000001
I 0 00000000
R 5 00000003
F 0 00000000
S 0 00000004
W 0 00000003
R 5 00000002
I 0 00000000
M 0 00000000
W 4 00000000
I 0 00000007
M 0 00000064
M 1 0000012c
M 2 00000188

// ==== verilog.f ====
hdl/motor_pwm_pkg.sv
hdl/pwm_wb_regs.sv
hdl/pwm_carrier_timing.sv
hdl/ds_pwm_driver.sv
hdl/motor_pwm_top.sv
sim/tb_motor_pwm.sv

// ==== Bender.yml ====
package:
  name: motor_pwm

sources:
  - hdl/motor_pwm_pkg.sv
  - hdl/pwm_wb_regs.sv
  - hdl/pwm_carrier_timing.sv
  - hdl/ds_pwm_driver.sv
  - hdl/motor_pwm_top.sv
  - target: simulation
    files:
      - sim/tb_motor_pwm.sv
